// File: test/mci_vectors.txt
# W addr data user err | R addr user rdata err | B brkpoint | P generic_out
# A fatal non_fatal exp_fatal exp_non_fatal | I output level (mcu_rst cptra_rst mci_intr nmi_intr fatal non_fatal)
B 1
I mcu_rst 0
I cptra_rst 0
R 018 00000007 ffffffff 0
R 028 00000007 ffffffff 0
R 040 00000007 00000000 0
R 044 00000007 00000000 0
R 054 00000007 00000000 0
R 000 00000007 00000001 0
W 004 00000001 00000007 1
I mcu_rst 0
R 000 00000007 00000001 0
W 004 00000001 00001001 0
I mcu_rst 1
I cptra_rst 0
W 004 00000003 00001001 0
I cptra_rst 1
R 000 00000007 00000003 0
W 054 c0ffee11 00000007 0
R 054 00000007 c0ffee11 0
P c0ffee11
R 050 00000007 5a3c96e1 0
R 100 00000007 00000000 1
W 0fc 12345678 00000007 1
W 048 ffffffff 00000007 0
A 00000110 00000003 1 1
W 040 00000100 00000007 0
A 00000110 00000003 1 1
W 040 00000110 00000007 0
A 00000110 00000003 0 1
W 044 00000003 00000007 0
A 00000110 00000003 0 0
R 048 00000007 00000110 0
W 018 00000004 00000007 0
W 028 00000004 00000007 0
W 020 00000001 00000007 0
W 010 00000001 00000007 0
I mci_intr 1
I nmi_intr 1
I fatal 1
R 030 00000007 00000003 0
W 010 00000000 00000007 0
W 030 00000001 00000007 0
I mci_intr 0
R 030 00000007 00000002 0
W 020 00000000 00000007 0
W 030 00000002 00000007 0
I nmi_intr 0
I fatal 0
W 008 00000001 00000007 1
W 008 00000001 00001001 0
I mcu_rst 0
I cptra_rst 1
I mcu_rst 1
R 000 00000007 0000000b 0

// File: vlog.f
verilog/mci_pkg.sv
verilog/mci_bus_decode.sv
verilog/mci_csr.sv
verilog/mci_wdt.sv
verilog/mci_boot_seqr.sv
verilog/mci_top.sv
test/tb_mci_top.sv

// File: test/tb_mci_top.sv
// Testbench for the MCU control block
// Runs bus accesses and output checks from a vector file
`timescale 1ns/1ps
module tb_mci_top;

    localparam logic [31:0] STRAP_USER    = 32'h0000_1001;
    // The vector file expects this value back from GENERIC_IN
    localparam logic [31:0] GENERIC_IN    = 32'h5a3c_96e1;
    localparam int          BUS_TIMEOUT   = 50;
    localparam int          LEVEL_TIMEOUT = 500;

    logic                           clk;
    logic                           rst_n_i;
    mci_pkg::mci_req_t              req;
    logic                           req_valid;
    logic                           req_ready;
    mci_pkg::mci_rsp_t              rsp;
    logic                           rsp_valid;
    logic                           rsp_ready;
    logic [31:0]                    strap_user;
    logic                           brkpoint;
    logic [mci_pkg::MCI_DATA_W-1:0] agg_fatal;
    logic [mci_pkg::MCI_DATA_W-1:0] agg_non_fatal;
    logic [mci_pkg::MCI_DATA_W-1:0] generic_in;
    logic [mci_pkg::MCI_DATA_W-1:0] generic_out;
    logic                           all_error_fatal;
    logic                           all_error_non_fatal;
    logic                           mcu_rst_b;
    logic                           cptra_rst_b;
    logic                           mci_intr;
    logic                           nmi_intr;
    int                             error_count;

    mci_top #(
        .MIN_MCU_RST_COUNTER_WIDTH(4)
    ) dut0 (
        .clk                     (clk),
        .rst_n_i                 (rst_n_i),
        .req_i                   (req),
        .req_valid_i             (req_valid),
        .req_ready_o             (req_ready),
        .rsp_o                   (rsp),
        .rsp_valid_o             (rsp_valid),
        .rsp_ready_i             (rsp_ready),
        .strap_soc_config_user_i (strap_user),
        .mci_boot_seq_brkpoint_i (brkpoint),
        .agg_error_fatal_i       (agg_fatal),
        .agg_error_non_fatal_i   (agg_non_fatal),
        .generic_input_i         (generic_in),
        .generic_output_o        (generic_out),
        .all_error_fatal_o       (all_error_fatal),
        .all_error_non_fatal_o   (all_error_non_fatal),
        .mcu_rst_b_o             (mcu_rst_b),
        .cptra_rst_b_o           (cptra_rst_b),
        .mci_intr_o              (mci_intr),
        .nmi_intr_o              (nmi_intr)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////
    // Failure handling
    ////////////////////
    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
            stop_run();
        end
    endtask

    task automatic timed_out(input string what);
        error_count++;
        $display("Timed out while waiting for %s", what);
        stop_run();
    endtask

    task automatic bad_vector(input logic [7:0] op);
        error_count++;
        $display("Vector line with opcode %c is malformed or unknown", op);
        stop_run();
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    task automatic apply_reset(input logic brk_level);
        @(negedge clk);
        rst_n_i  = 1'b0;
        brkpoint = brk_level;
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
    endtask

    // One request and its response, which the host holds off for one cycle
    task automatic bus_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, input logic [31:0] user,
                              output logic [31:0] rdata, output logic error);
        int cycles;
        @(negedge clk);
        req.write  = write;
        req.addr   = addr;
        req.wdata  = wdata;
        req.user   = user;
        req_valid  = 1'b1;
        rsp_ready  = 1'b0;
        cycles     = 0;
        while (!req_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > BUS_TIMEOUT) timed_out("req_ready_o");
        end
        // Accepted on the rising edge in between
        @(negedge clk);
        req_valid = 1'b0;
        cycles    = 0;
        while (!rsp_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > BUS_TIMEOUT) timed_out("rsp_valid_o");
        end
        check_value("cycles from accept to rsp_valid_o", cycles, 0);
        check_value("req_ready_o with a response pending", req_ready, 1'b0);
        // Response stays pending through one edge of back-pressure
        @(negedge clk);
        check_value("rsp_valid_o under back-pressure", rsp_valid, 1'b1);
        check_value("req_ready_o under back-pressure", req_ready, 1'b0);
        rdata     = rsp.rdata;
        error     = rsp.error;
        rsp_ready = 1'b1;
    endtask

    function automatic int output_index(input logic [8*12-1:0] name);
        case (name)
            "mcu_rst":   return 0;
            "cptra_rst": return 1;
            "mci_intr":  return 2;
            "nmi_intr":  return 3;
            "fatal":     return 4;
            "non_fatal": return 5;
            default:     return -1;
        endcase
    endfunction

    function automatic logic output_level(input int idx);
        case (idx)
            0:       return mcu_rst_b;
            1:       return cptra_rst_b;
            2:       return mci_intr;
            3:       return nmi_intr;
            4:       return all_error_fatal;
            default: return all_error_non_fatal;
        endcase
    endfunction

    task automatic wait_level(input logic [8*12-1:0] name, input logic level);
        int idx;
        int cycles;
        idx    = output_index(name);
        cycles = 0;
        if (idx < 0) begin
            error_count++;
            $display("Vector names an unknown output %0s", name);
            stop_run();
        end else begin
            while (output_level(idx) !== level) begin
                @(negedge clk);
                cycles++;
                if (cycles > LEVEL_TIMEOUT) timed_out($sformatf("%0s to reach %0b", name, level));
            end
        end
    endtask

    ////////////////////
    // Vector loop
    ////////////////////
    initial begin : run_vectors
        int               fd;
        int               n;
        int               fields;
        logic [7:0]       op;
        logic [8*128-1:0] comment;
        logic [8*12-1:0]  name;
        logic [11:0]      addr;
        logic [31:0]      data;
        logic [31:0]      user;
        logic [31:0]      exp_data;
        logic [31:0]      rdata;
        logic [31:0]      vec_fatal;
        logic [31:0]      vec_non_fatal;
        logic             exp_err;
        logic             exp_fatal;
        logic             exp_non_fatal;
        logic             err;

        error_count   = 0;
        rst_n_i       = 1'b0;
        req           = '0;
        req_valid     = 1'b0;
        rsp_ready     = 1'b1;
        strap_user    = STRAP_USER;
        brkpoint      = 1'b0;
        agg_fatal     = '0;
        agg_non_fatal = '0;
        generic_in    = GENERIC_IN;
        apply_reset(1'b0);

        fd = $fopen("test/mci_vectors.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Cannot open the vector file test/mci_vectors.txt");
            stop_run();
        end
        n = $fscanf(fd, " %c", op);
        while (n == 1) begin
            case (op)
                "#": fields = $fgets(comment, fd);
                "B": begin
                    fields = $fscanf(fd, "%h", exp_err);
                    if (fields != 1) bad_vector(op);
                    apply_reset(exp_err);
                end
                "W": begin
                    fields = $fscanf(fd, "%h %h %h %h", addr, data, user, exp_err);
                    if (fields != 4) bad_vector(op);
                    bus_access(1'b1, addr, data, user, rdata, err);
                    check_value($sformatf("error flag of write to %h", addr), err, exp_err);
                end
                "R": begin
                    fields = $fscanf(fd, "%h %h %h %h", addr, user, exp_data, exp_err);
                    if (fields != 4) bad_vector(op);
                    bus_access(1'b0, addr, '0, user, rdata, err);
                    check_value($sformatf("read data at %h", addr), rdata, exp_data);
                    check_value($sformatf("error flag of read at %h", addr), err, exp_err);
                end
                "A": begin
                    fields = $fscanf(fd, "%h %h %h %h", vec_fatal, vec_non_fatal,
                                     exp_fatal, exp_non_fatal);
                    if (fields != 4) bad_vector(op);
                    @(negedge clk);
                    agg_fatal     = vec_fatal;
                    agg_non_fatal = vec_non_fatal;
                    @(negedge clk);
                    check_value("all_error_fatal_o", all_error_fatal, exp_fatal);
                    check_value("all_error_non_fatal_o", all_error_non_fatal, exp_non_fatal);
                end
                "I": begin
                    fields = $fscanf(fd, "%s %h", name, exp_err);
                    if (fields != 2) bad_vector(op);
                    wait_level(name, exp_err);
                end
                "P": begin
                    fields = $fscanf(fd, "%h", exp_data);
                    if (fields != 1) bad_vector(op);
                    check_value("generic_output_o", generic_out, exp_data);
                end
                default: bad_vector(op);
            endcase
            n = $fscanf(fd, " %c", op);
        end
        $fclose(fd);

        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog/mci_top.sv
// MCU control block top: bus decode, register bank, watchdog and boot sequencer
`timescale 1ns/1ps
module mci_top #(
    parameter int MIN_MCU_RST_COUNTER_WIDTH = 4
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    // Host bus
    input  mci_pkg::mci_req_t              req_i,
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    output mci_pkg::mci_rsp_t              rsp_o,
    output logic                           rsp_valid_o,
    input  logic                           rsp_ready_i,
    // Straps and subsystem inputs
    input  logic [mci_pkg::MCI_USER_W-1:0] strap_soc_config_user_i,
    input  logic                           mci_boot_seq_brkpoint_i,
    input  logic [mci_pkg::MCI_DATA_W-1:0] agg_error_fatal_i,
    input  logic [mci_pkg::MCI_DATA_W-1:0] agg_error_non_fatal_i,
    input  logic [mci_pkg::MCI_DATA_W-1:0] generic_input_i,
    // Outputs to the SoC
    output logic [mci_pkg::MCI_DATA_W-1:0] generic_output_o,
    output logic                           all_error_fatal_o,
    output logic                           all_error_non_fatal_o,
    output logic                           mcu_rst_b_o,
    output logic                           cptra_rst_b_o,
    output logic                           mci_intr_o,
    output logic                           nmi_intr_o
);

    mci_pkg::mci_csr_acc_t          csr_acc;
    logic [mci_pkg::MCI_DATA_W-1:0] csr_rdata;
    mci_pkg::mci_wdt_cfg_t          wdt_cfg;
    mci_pkg::mci_wdt_sts_t          wdt_sts;
    mci_pkg::mci_boot_ctrl_t        boot_ctrl;
    mci_pkg::mci_boot_state_e       boot_state;
    logic                           mcu_reset_once;

    mci_bus_decode i_bus_decode (
        .clk                     (clk),
        .rst_n_i                 (rst_n_i),
        .req_i                   (req_i),
        .req_valid_i             (req_valid_i),
        .req_ready_o             (req_ready_o),
        .rsp_o                   (rsp_o),
        .rsp_valid_o             (rsp_valid_o),
        .rsp_ready_i             (rsp_ready_i),
        .strap_soc_config_user_i (strap_soc_config_user_i),
        .csr_rdata_i             (csr_rdata),
        .acc_o                   (csr_acc)
    );

    mci_csr i_csr (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .acc_i                 (csr_acc),
        .wdt_sts_i             (wdt_sts),
        .boot_state_i          (boot_state),
        .mcu_reset_once_i      (mcu_reset_once),
        .agg_error_fatal_i     (agg_error_fatal_i),
        .agg_error_non_fatal_i (agg_error_non_fatal_i),
        .generic_input_i       (generic_input_i),
        .rdata_o               (csr_rdata),
        .wdt_cfg_o             (wdt_cfg),
        .boot_ctrl_o           (boot_ctrl),
        .generic_output_o      (generic_output_o),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o),
        .mci_intr_o            (mci_intr_o)
    );

    mci_wdt i_wdt (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cfg_i      (wdt_cfg),
        .sts_o      (wdt_sts),
        .nmi_intr_o (nmi_intr_o)
    );

    mci_boot_seqr #(
        .MIN_MCU_RST_COUNTER_WIDTH(MIN_MCU_RST_COUNTER_WIDTH)
    ) i_boot_seqr (
        .clk                     (clk),
        .rst_n_i                 (rst_n_i),
        .boot_ctrl_i             (boot_ctrl),
        .mci_boot_seq_brkpoint_i (mci_boot_seq_brkpoint_i),
        .mcu_rst_b_o             (mcu_rst_b_o),
        .cptra_rst_b_o           (cptra_rst_b_o),
        .boot_state_o            (boot_state),
        .mcu_reset_once_o        (mcu_reset_once)
    );

endmodule

// File: verilog/mci_boot_seqr.sv
// Boot sequencer: orders MCU and Caliptra reset release, counted MCU reset on request
`timescale 1ns/1ps
module mci_boot_seqr #(
    parameter int MIN_MCU_RST_COUNTER_WIDTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  mci_pkg::mci_boot_ctrl_t  boot_ctrl_i,
    input  logic                     mci_boot_seq_brkpoint_i,
    output logic                     mcu_rst_b_o,
    output logic                     cptra_rst_b_o,
    output mci_pkg::mci_boot_state_e boot_state_o,
    output logic                     mcu_reset_once_o
);

    mci_pkg::mci_boot_state_e             state_q;
    mci_pkg::mci_boot_state_e             state_d;
    logic [MIN_MCU_RST_COUNTER_WIDTH-1:0] hold_cnt_q;
    logic                                 hold_done;
    logic                                 mcu_rst_b_q;
    logic                                 cptra_rst_b_q;
    logic                                 reset_once_q;

    // Hold ends when the counter wraps
    assign hold_done = &hold_cnt_q;

    ////////////////////
    // Next state
    ////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            mci_pkg::BOOT_IDLE: begin
                if (mci_boot_seq_brkpoint_i) begin
                    state_d = mci_pkg::BOOT_BRKPOINT;
                end else begin
                    state_d = mci_pkg::BOOT_MCU_RUN;
                end
            end
            mci_pkg::BOOT_BRKPOINT: begin
                if (boot_ctrl_i.bootfsm_go) begin
                    state_d = mci_pkg::BOOT_MCU_RUN;
                end
            end
            mci_pkg::BOOT_MCU_RUN: begin
                if (boot_ctrl_i.caliptra_go) begin
                    state_d = mci_pkg::BOOT_DONE;
                end
            end
            mci_pkg::BOOT_DONE: begin
                if (boot_ctrl_i.mcu_req) begin
                    state_d = mci_pkg::BOOT_MCU_RST;
                end
            end
            mci_pkg::BOOT_MCU_RST: begin
                if (hold_done) begin
                    state_d = mci_pkg::BOOT_DONE;
                end
            end
            default: state_d = mci_pkg::BOOT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q       <= mci_pkg::BOOT_IDLE;
            hold_cnt_q    <= '0;
            mcu_rst_b_q   <= 1'b0;
            cptra_rst_b_q <= 1'b0;
            reset_once_q  <= 1'b0;
        end else begin
            state_q       <= state_d;
            // Resets follow the state being entered
            mcu_rst_b_q   <= (state_d == mci_pkg::BOOT_MCU_RUN) ||
                             (state_d == mci_pkg::BOOT_DONE);
            cptra_rst_b_q <= (state_d == mci_pkg::BOOT_DONE) ||
                             (state_d == mci_pkg::BOOT_MCU_RST);
            if (state_q == mci_pkg::BOOT_MCU_RST) begin
                hold_cnt_q <= hold_cnt_q + 1'b1;
            end else begin
                hold_cnt_q <= '0;
            end
            if ((state_q == mci_pkg::BOOT_MCU_RST) && hold_done) begin
                reset_once_q <= 1'b1;
            end
        end
    end

    assign mcu_rst_b_o      = mcu_rst_b_q;
    assign cptra_rst_b_o    = cptra_rst_b_q;
    assign boot_state_o     = state_q;
    assign mcu_reset_once_o = reset_once_q;

endmodule

// File: verilog/mci_wdt.sv
// Cascaded two-stage watchdog, stage 2 runs only after stage 1 times out
`timescale 1ns/1ps
module mci_wdt (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  mci_pkg::mci_wdt_cfg_t cfg_i,
    output mci_pkg::mci_wdt_sts_t sts_o,
    output logic                  nmi_intr_o
);

    logic [1:0]                     run;
    logic [1:0]                     restart;
    logic [1:0]                     serviced;
    logic [mci_pkg::MCI_DATA_W-1:0] period    [2];
    logic [mci_pkg::MCI_DATA_W-1:0] count_q   [2];
    logic                           timeout_q [2];

    // Index 0 is timer1, index 1 is timer2
    assign run      = {cfg_i.t2_en && timeout_q[0], cfg_i.t1_en};
    assign restart  = {cfg_i.t2_restart, cfg_i.t1_restart};
    assign serviced = {cfg_i.t2_serviced, cfg_i.t1_serviced};
    assign period[0] = cfg_i.t1_period;
    assign period[1] = cfg_i.t2_period;

    for (genvar i = 0; i < 2; i++) begin : g_stage
        always_ff @(posedge clk) begin
            if (!rst_n_i) begin
                count_q[i]   <= '0;
                timeout_q[i] <= 1'b0;
            end else if (serviced[i]) begin
                count_q[i]   <= '0;
                timeout_q[i] <= 1'b0;
            end else if (restart[i]) begin
                count_q[i] <= '0;
            end else if (run[i] && !timeout_q[i]) begin
                count_q[i] <= count_q[i] + 1'b1;
                // Sticky until serviced
                if (count_q[i] == period[i]) begin
                    timeout_q[i] <= 1'b1;
                end
            end
        end
    end

    assign sts_o.t1_timeout = timeout_q[0];
    assign sts_o.t2_timeout = timeout_q[1];
    assign nmi_intr_o       = timeout_q[1];

endmodule

// File: verilog/mci_csr.sv
// Register bank for boot control, watchdog, error masks and generic wires
`timescale 1ns/1ps
module mci_csr (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  mci_pkg::mci_csr_acc_t          acc_i,
    input  mci_pkg::mci_wdt_sts_t          wdt_sts_i,
    input  mci_pkg::mci_boot_state_e       boot_state_i,
    input  logic                           mcu_reset_once_i,
    input  logic [mci_pkg::MCI_DATA_W-1:0] agg_error_fatal_i,
    input  logic [mci_pkg::MCI_DATA_W-1:0] agg_error_non_fatal_i,
    input  logic [mci_pkg::MCI_DATA_W-1:0] generic_input_i,
    output logic [mci_pkg::MCI_DATA_W-1:0] rdata_o,
    output mci_pkg::mci_wdt_cfg_t          wdt_cfg_o,
    output mci_pkg::mci_boot_ctrl_t        boot_ctrl_o,
    output logic [mci_pkg::MCI_DATA_W-1:0] generic_output_o,
    output logic                           all_error_fatal_o,
    output logic                           all_error_non_fatal_o,
    output logic                           mci_intr_o
);

    logic [1:0]                     boot_go_q;
    logic                           mcu_req_q;
    logic                           t1_en_q;
    logic                           t2_en_q;
    logic                           t1_restart_q;
    logic                           t2_restart_q;
    logic                           t1_serviced_q;
    logic                           t2_serviced_q;
    logic [mci_pkg::MCI_DATA_W-1:0] t1_period_q;
    logic [mci_pkg::MCI_DATA_W-1:0] t2_period_q;
    logic [mci_pkg::MCI_DATA_W-1:0] fatal_mask_q;
    logic [mci_pkg::MCI_DATA_W-1:0] non_fatal_mask_q;
    logic [mci_pkg::MCI_DATA_W-1:0] gen_out_q;

    ////////////////////
    // Register writes
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            boot_go_q        <= '0;
            mcu_req_q        <= 1'b0;
            t1_en_q          <= 1'b0;
            t2_en_q          <= 1'b0;
            t1_restart_q     <= 1'b0;
            t2_restart_q     <= 1'b0;
            t1_serviced_q    <= 1'b0;
            t2_serviced_q    <= 1'b0;
            t1_period_q      <= '1;
            t2_period_q      <= '1;
            fatal_mask_q     <= '0;
            non_fatal_mask_q <= '0;
            gen_out_q        <= '0;
        end else begin
            // Write-1 pulses drop after one cycle
            mcu_req_q     <= 1'b0;
            t1_restart_q  <= 1'b0;
            t2_restart_q  <= 1'b0;
            t1_serviced_q <= 1'b0;
            t2_serviced_q <= 1'b0;
            if (acc_i.wr_en) begin
                case (acc_i.idx)
                    mci_pkg::REG_BOOT_GO:            boot_go_q        <= acc_i.wdata[1:0];
                    mci_pkg::REG_RESET_REQUEST:      mcu_req_q        <= acc_i.wdata[0];
                    mci_pkg::REG_WDT_T1_EN:          t1_en_q          <= acc_i.wdata[0];
                    mci_pkg::REG_WDT_T1_CTRL:        t1_restart_q     <= acc_i.wdata[0];
                    mci_pkg::REG_WDT_T1_PERIOD:      t1_period_q      <= acc_i.wdata;
                    mci_pkg::REG_WDT_T2_EN:          t2_en_q          <= acc_i.wdata[0];
                    mci_pkg::REG_WDT_T2_CTRL:        t2_restart_q     <= acc_i.wdata[0];
                    mci_pkg::REG_WDT_T2_PERIOD:      t2_period_q      <= acc_i.wdata;
                    mci_pkg::REG_WDT_STATUS: begin
                        t1_serviced_q <= acc_i.wdata[0];
                        t2_serviced_q <= acc_i.wdata[1];
                    end
                    mci_pkg::REG_ERR_FATAL_MASK:     fatal_mask_q     <= acc_i.wdata;
                    mci_pkg::REG_ERR_NON_FATAL_MASK: non_fatal_mask_q <= acc_i.wdata;
                    mci_pkg::REG_GENERIC_OUT:        gen_out_q        <= acc_i.wdata;
                    // Read-only registers ignore writes
                    default: ;
                endcase
            end
        end
    end

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        rdata_o = '0;
        if (acc_i.rd_en) begin
            case (acc_i.idx)
                mci_pkg::REG_BOOT_STATUS: begin
                    rdata_o[2:0] = boot_state_i;
                    rdata_o[3]   = mcu_reset_once_i;
                end
                mci_pkg::REG_BOOT_GO:            rdata_o[1:0] = boot_go_q;
                mci_pkg::REG_RESET_REQUEST:      rdata_o[0]   = mcu_req_q;
                mci_pkg::REG_WDT_T1_EN:          rdata_o[0]   = t1_en_q;
                mci_pkg::REG_WDT_T1_CTRL:        rdata_o[0]   = t1_restart_q;
                mci_pkg::REG_WDT_T1_PERIOD:      rdata_o      = t1_period_q;
                mci_pkg::REG_WDT_T2_EN:          rdata_o[0]   = t2_en_q;
                mci_pkg::REG_WDT_T2_CTRL:        rdata_o[0]   = t2_restart_q;
                mci_pkg::REG_WDT_T2_PERIOD:      rdata_o      = t2_period_q;
                mci_pkg::REG_WDT_STATUS: begin
                    rdata_o[0] = wdt_sts_i.t1_timeout;
                    rdata_o[1] = wdt_sts_i.t2_timeout;
                end
                mci_pkg::REG_ERR_FATAL_MASK:     rdata_o      = fatal_mask_q;
                mci_pkg::REG_ERR_NON_FATAL_MASK: rdata_o      = non_fatal_mask_q;
                mci_pkg::REG_AGG_ERR_FATAL:      rdata_o      = agg_error_fatal_i;
                mci_pkg::REG_GENERIC_IN:         rdata_o      = generic_input_i;
                mci_pkg::REG_GENERIC_OUT:        rdata_o      = gen_out_q;
                default: ;
            endcase
        end
    end

    assign wdt_cfg_o.t1_en       = t1_en_q;
    assign wdt_cfg_o.t2_en       = t2_en_q;
    assign wdt_cfg_o.t1_restart  = t1_restart_q;
    assign wdt_cfg_o.t2_restart  = t2_restart_q;
    assign wdt_cfg_o.t1_serviced = t1_serviced_q;
    assign wdt_cfg_o.t2_serviced = t2_serviced_q;
    assign wdt_cfg_o.t1_period   = t1_period_q;
    assign wdt_cfg_o.t2_period   = t2_period_q;

    assign boot_ctrl_o.bootfsm_go  = boot_go_q[0];
    assign boot_ctrl_o.caliptra_go = boot_go_q[1];
    assign boot_ctrl_o.mcu_req     = mcu_req_q;

    assign generic_output_o = gen_out_q;

    // Mask bit set hides that error; watchdog stages feed in unmasked
    assign all_error_fatal_o     = (|(agg_error_fatal_i & ~fatal_mask_q)) ||
                                   wdt_sts_i.t2_timeout;
    assign all_error_non_fatal_o = (|(agg_error_non_fatal_i & ~non_fatal_mask_q)) ||
                                   wdt_sts_i.t1_timeout;
    assign mci_intr_o            = wdt_sts_i.t1_timeout;

endmodule

// File: verilog/mci_bus_decode.sv
// Host request decode: address map, privilege check and the single response slot
`timescale 1ns/1ps
module mci_bus_decode (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  mci_pkg::mci_req_t              req_i,
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    output mci_pkg::mci_rsp_t              rsp_o,
    output logic                           rsp_valid_o,
    input  logic                           rsp_ready_i,
    input  logic [mci_pkg::MCI_USER_W-1:0] strap_soc_config_user_i,
    input  logic [mci_pkg::MCI_DATA_W-1:0] csr_rdata_i,
    output mci_pkg::mci_csr_acc_t          acc_o
);

    mci_pkg::mci_reg_e idx;
    mci_pkg::mci_rsp_t rsp_q;
    logic              rsp_valid_q;
    logic              accept;
    logic              priv_reg;
    logic              err;

    // Byte address to register index
    always_comb begin
        case (req_i.addr)
            12'h000: idx = mci_pkg::REG_BOOT_STATUS;
            12'h004: idx = mci_pkg::REG_BOOT_GO;
            12'h008: idx = mci_pkg::REG_RESET_REQUEST;
            12'h010: idx = mci_pkg::REG_WDT_T1_EN;
            12'h014: idx = mci_pkg::REG_WDT_T1_CTRL;
            12'h018: idx = mci_pkg::REG_WDT_T1_PERIOD;
            12'h020: idx = mci_pkg::REG_WDT_T2_EN;
            12'h024: idx = mci_pkg::REG_WDT_T2_CTRL;
            12'h028: idx = mci_pkg::REG_WDT_T2_PERIOD;
            12'h030: idx = mci_pkg::REG_WDT_STATUS;
            12'h040: idx = mci_pkg::REG_ERR_FATAL_MASK;
            12'h044: idx = mci_pkg::REG_ERR_NON_FATAL_MASK;
            12'h048: idx = mci_pkg::REG_AGG_ERR_FATAL;
            12'h050: idx = mci_pkg::REG_GENERIC_IN;
            12'h054: idx = mci_pkg::REG_GENERIC_OUT;
            default: idx = mci_pkg::REG_NONE;
        endcase
    end

    // Boot control writes only from the SoC config user
    assign priv_reg = (idx == mci_pkg::REG_BOOT_GO) || (idx == mci_pkg::REG_RESET_REQUEST);
    assign err      = (idx == mci_pkg::REG_NONE) ||
                      (req_i.write && priv_reg && (req_i.user != strap_soc_config_user_i));

    // One request in flight, slot frees when the response leaves
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    assign acc_o.wr_en = accept && req_i.write && !err;
    assign acc_o.rd_en = accept && !req_i.write && !err;
    assign acc_o.idx   = idx;
    assign acc_o.wdata = req_i.wdata;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Read data is already zero for writes and errors
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_q.rdata <= csr_rdata_i;
            rsp_q.error <= err;
        end
    end

    assign rsp_o       = rsp_q;
    assign rsp_valid_o = rsp_valid_q;

endmodule

// File: verilog/mci_pkg.sv
// Shared widths, bus structs and encodings for the MCU control block
package mci_pkg;

    localparam int MCI_DATA_W = 32;
    localparam int MCI_ADDR_W = 12;
    localparam int MCI_USER_W = 32;

    ////////////////////
    // Host bus
    ////////////////////
    typedef struct packed {
        logic                  write;
        logic [MCI_ADDR_W-1:0] addr;
        logic [MCI_DATA_W-1:0] wdata;
        logic [MCI_USER_W-1:0] user;
    } mci_req_t;

    typedef struct packed {
        logic [MCI_DATA_W-1:0] rdata;
        logic                  error;
    } mci_rsp_t;

    // Register index, REG_NONE for any unmapped address
    typedef enum logic [3:0] {
        REG_BOOT_STATUS,
        REG_BOOT_GO,
        REG_RESET_REQUEST,
        REG_WDT_T1_EN,
        REG_WDT_T1_CTRL,
        REG_WDT_T1_PERIOD,
        REG_WDT_T2_EN,
        REG_WDT_T2_CTRL,
        REG_WDT_T2_PERIOD,
        REG_WDT_STATUS,
        REG_ERR_FATAL_MASK,
        REG_ERR_NON_FATAL_MASK,
        REG_AGG_ERR_FATAL,
        REG_GENERIC_IN,
        REG_GENERIC_OUT,
        REG_NONE
    } mci_reg_e;

    typedef struct packed {
        logic                  wr_en;
        logic                  rd_en;
        mci_reg_e              idx;
        logic [MCI_DATA_W-1:0] wdata;
    } mci_csr_acc_t;

    ////////////////////
    // Watchdog
    ////////////////////
    typedef struct packed {
        logic                  t1_en;
        logic                  t2_en;
        logic                  t1_restart;
        logic                  t2_restart;
        logic                  t1_serviced;
        logic                  t2_serviced;
        logic [MCI_DATA_W-1:0] t1_period;
        logic [MCI_DATA_W-1:0] t2_period;
    } mci_wdt_cfg_t;

    typedef struct packed {
        logic t1_timeout;
        logic t2_timeout;
    } mci_wdt_sts_t;

    ////////////////////
    // Boot sequencer
    ////////////////////
    typedef enum logic [2:0] {
        BOOT_IDLE,
        BOOT_BRKPOINT,
        BOOT_MCU_RUN,
        BOOT_DONE,
        BOOT_MCU_RST
    } mci_boot_state_e;

    typedef struct packed {
        logic bootfsm_go;
        logic caliptra_go;
        logic mcu_req;
    } mci_boot_ctrl_t;

endpackage
